// File: include/rv_exec_consts.svh
`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

// integer datapath width
`define RV_XLEN 64

// shift amount width, low bits of operand b
`define RV_SHAMT_W 6

// architectural register file
`define RV_REG_NUM 32

// register index width
`define RV_REG_AW 5

// base encoding length
`define RV_INSTR_W 32

`endif

// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_OP     = 7'b0110011
  } opcode_t;

  // funct3 codes shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7[5], picks SUB over ADD and SRA over SRL
  localparam int ALT_BIT = 30;

endpackage

// File: verilog/rv_uop_pkg.sv
package rv_uop_pkg;

  // alu operation carried in the execute stage
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // lui, b already holds the upper immediate
    ALU_PASS_B
  } alu_op_t;

  // source of alu operand b
  typedef enum logic {
    B_REG,
    B_IMM
  } b_sel_t;

endpackage

// File: verilog/rv_alu.sv
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module rv_alu (
  input  rv_uop_pkg::alu_op_t  i_op,
  input  logic [`RV_XLEN-1:0]  i_a,
  input  logic [`RV_XLEN-1:0]  i_b,
  output logic [`RV_XLEN-1:0]  o_result
);

  logic [`RV_SHAMT_W-1:0] shamt;
  logic                   lt_s;
  logic                   lt_u;

  // rv64 shifts only look at the low 6 bits
  assign shamt = i_b[`RV_SHAMT_W-1:0];

  assign lt_s = $signed(i_a) < $signed(i_b);
  assign lt_u = i_a < i_b;

  always_comb begin
    case (i_op)
      rv_uop_pkg::ALU_ADD: begin
        o_result = i_a + i_b;
      end
      rv_uop_pkg::ALU_SUB: begin
        o_result = i_a - i_b;
      end
      rv_uop_pkg::ALU_SLL: begin
        o_result = i_a << shamt;
      end
      rv_uop_pkg::ALU_SLT: begin
        o_result = {{(`RV_XLEN-1){1'b0}}, lt_s};
      end
      rv_uop_pkg::ALU_SLTU: begin
        o_result = {{(`RV_XLEN-1){1'b0}}, lt_u};
      end
      rv_uop_pkg::ALU_XOR: begin
        o_result = i_a ^ i_b;
      end
      rv_uop_pkg::ALU_SRL: begin
        o_result = i_a >> shamt;
      end
      rv_uop_pkg::ALU_SRA: begin
        // sign fill from bit 63
        o_result = $signed(i_a) >>> shamt;
      end
      rv_uop_pkg::ALU_OR: begin
        o_result = i_a | i_b;
      end
      rv_uop_pkg::ALU_AND: begin
        o_result = i_a & i_b;
      end
      default: begin
        o_result = i_b;
      end
    endcase
  end

endmodule

// File: verilog/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_REG_AW-1:0] i_rs1,
  input  logic                  i_rs1_ren,
  input  logic [`RV_REG_AW-1:0] i_rs2,
  input  logic                  i_rs2_ren,
  input  logic [`RV_REG_AW-1:0] i_rd,
  input  logic                  i_rd_wen,
  input  logic [`RV_XLEN-1:0]   i_rd_data,
  output logic [`RV_XLEN-1:0]   o_rs1_data,
  output logic [`RV_XLEN-1:0]   o_rs2_data,
  output logic [`RV_XLEN-1:0]   o_regs [`RV_REG_NUM]
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_NUM];

  // x0 is hardwired, writes to it are dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && i_rd != '0) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  // read ports
  assign o_rs1_data = (rst || !i_rs1_ren) ? '0 : regs[i_rs1];
  assign o_rs2_data = (rst || !i_rs2_ren) ? '0 : regs[i_rs2];

  // state view for difftest, shows this cycle's write early
  for (genvar g = 0; g < `RV_REG_NUM; g++) begin : g_view
    if (g == 0) begin : g_zero
      assign o_regs[g] = regs[g];
    end else begin : g_bypass
      localparam logic [`RV_REG_AW-1:0] IDX = g;
      assign o_regs[g] = (i_rd_wen && i_rd == IDX) ? i_rd_data : regs[g];
    end
  end

endmodule

// File: verilog/rv_decode.sv
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module rv_decode (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_instr_valid,
  input  logic [`RV_INSTR_W-1:0] i_instr,
  input  logic [`RV_XLEN-1:0]    i_rs1_data,
  input  logic [`RV_XLEN-1:0]    i_rs2_data,
  input  logic                   i_ex_wen,
  input  logic [`RV_REG_AW-1:0]  i_ex_rd,
  input  logic [`RV_XLEN-1:0]    i_ex_result,
  input  logic                   i_wb_wen,
  input  logic [`RV_REG_AW-1:0]  i_wb_rd,
  input  logic [`RV_XLEN-1:0]    i_wb_data,
  output logic [`RV_REG_AW-1:0]  o_rs1,
  output logic                   o_rs1_ren,
  output logic [`RV_REG_AW-1:0]  o_rs2,
  output logic                   o_rs2_ren,
  output logic                   o_ex_valid,
  output logic                   o_ex_illegal,
  output rv_uop_pkg::alu_op_t    o_ex_op,
  output logic [`RV_XLEN-1:0]    o_ex_a,
  output logic [`RV_XLEN-1:0]    o_ex_b,
  output logic [`RV_REG_AW-1:0]  o_ex_rd,
  output logic                   o_ex_wen
);

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic                   alt;
  logic [`RV_REG_AW-1:0]  rd;
  logic [`RV_XLEN-1:0]    imm_i;
  logic [`RV_XLEN-1:0]    imm_u;
  logic [`RV_XLEN-1:0]    imm;
  logic                   illegal;
  logic                   use_rs1;
  logic                   use_rs2;
  rv_uop_pkg::alu_op_t    op;
  rv_uop_pkg::b_sel_t     b_sel;
  logic [`RV_XLEN-1:0]    rs1_val;
  logic [`RV_XLEN-1:0]    rs2_val;
  logic [`RV_XLEN-1:0]    b_val;

  assign opcode = i_instr[6:0];
  assign rd     = i_instr[11:7];
  assign funct3 = i_instr[14:12];
  assign o_rs1  = i_instr[19:15];
  assign o_rs2  = i_instr[24:20];
  assign alt    = i_instr[rv_isa_pkg::ALT_BIT];

  assign imm_i = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[31:20]};
  assign imm_u = {{(`RV_XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};
  assign imm   = (opcode == rv_isa_pkg::OPC_LUI) ? imm_u : imm_i;

  // funct3 map, no SUBI so alt only counts for reg-reg add
  function automatic rv_uop_pkg::alu_op_t funct_op(
    input logic [2:0] f3,
    input logic       alt_bit,
    input logic       is_reg
  );
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: return (is_reg && alt_bit) ? rv_uop_pkg::ALU_SUB
                                                          : rv_uop_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     return rv_uop_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     return rv_uop_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    return rv_uop_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     return rv_uop_pkg::ALU_XOR;
      rv_isa_pkg::F3_SR:      return alt_bit ? rv_uop_pkg::ALU_SRA : rv_uop_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      return rv_uop_pkg::ALU_OR;
      default:                return rv_uop_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    illegal = 1'b0;
    use_rs1 = 1'b1;
    use_rs2 = 1'b0;
    b_sel   = rv_uop_pkg::B_IMM;
    op      = rv_uop_pkg::ALU_ADD;
    case (opcode)
      rv_isa_pkg::OPC_OP: begin
        use_rs2 = 1'b1;
        b_sel   = rv_uop_pkg::B_REG;
        op      = funct_op(funct3, alt, 1'b1);
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        op = funct_op(funct3, alt, 1'b0);
      end
      rv_isa_pkg::OPC_LUI: begin
        use_rs1 = 1'b0;
        op      = rv_uop_pkg::ALU_PASS_B;
      end
      default: begin
        illegal = 1'b1;
        use_rs1 = 1'b0;
      end
    endcase
  end

  assign o_rs1_ren = i_instr_valid & use_rs1;
  assign o_rs2_ren = i_instr_valid & use_rs2;

  // youngest pending write wins, x0 never forwarded
  function automatic logic [`RV_XLEN-1:0] fwd(
    input logic [`RV_REG_AW-1:0] idx,
    input logic                  ren,
    input logic [`RV_XLEN-1:0]   rf_data
  );
    if (!ren || idx == '0) begin
      return '0;
    end
    if (i_ex_wen && i_ex_rd == idx) begin
      return i_ex_result;
    end
    if (i_wb_wen && i_wb_rd == idx) begin
      return i_wb_data;
    end
    return rf_data;
  endfunction

  always_comb begin
    rs1_val = fwd(o_rs1, o_rs1_ren, i_rs1_data);
    rs2_val = fwd(o_rs2, o_rs2_ren, i_rs2_data);
  end

  assign b_val = (b_sel == rv_uop_pkg::B_REG) ? rs2_val : imm;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_ex_valid   <= 1'b0;
      o_ex_illegal <= 1'b0;
      o_ex_wen     <= 1'b0;
    end else begin
      o_ex_valid   <= i_instr_valid;
      o_ex_illegal <= i_instr_valid & illegal;
      o_ex_wen     <= i_instr_valid & ~illegal;
    end
  end

  always_ff @(posedge clk) begin
    o_ex_op <= op;
    o_ex_a  <= rs1_val;
    o_ex_b  <= b_val;
    o_ex_rd <= rd;
  end

  a_ex_idle_after_rst: assert property (@(posedge clk) rst |=> !o_ex_valid);

endmodule

// File: verilog/rv_commit.sv
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module rv_commit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_ex_valid,
  input  logic                  i_ex_illegal,
  input  logic [`RV_REG_AW-1:0] i_ex_rd,
  input  logic                  i_ex_wen,
  input  logic [`RV_XLEN-1:0]   i_result,
  output logic                  o_wb_valid,
  output logic                  o_wb_illegal,
  output logic [`RV_REG_AW-1:0] o_wb_rd,
  output logic                  o_wb_wen,
  output logic [`RV_XLEN-1:0]   o_wb_data
);

  // control side of the write-back register
  always_ff @(posedge clk) begin
    if (rst) begin
      o_wb_valid   <= 1'b0;
      o_wb_illegal <= 1'b0;
      o_wb_wen     <= 1'b0;
    end else begin
      o_wb_valid   <= i_ex_valid;
      o_wb_illegal <= i_ex_valid & i_ex_illegal;
      o_wb_wen     <= i_ex_valid & i_ex_wen;
    end
  end

  // result and destination, meaningful only with valid
  always_ff @(posedge clk) begin
    o_wb_rd   <= i_ex_rd;
    o_wb_data <= i_result;
  end

  // decode must never request a write for an illegal instruction
  a_wen_legal: assert property (
    @(posedge clk) disable iff (rst)
    o_wb_wen |-> (o_wb_valid && !o_wb_illegal)
  );

endmodule

// File: verilog/rv_exec_top.sv
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module rv_exec_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_instr_valid,
  input  logic [`RV_INSTR_W-1:0] i_instr,
  output logic                   o_commit_valid,
  output logic                   o_commit_illegal,
  output logic [`RV_REG_AW-1:0]  o_commit_rd,
  output logic                   o_commit_wen,
  output logic [`RV_XLEN-1:0]    o_commit_data,
  output logic [`RV_XLEN-1:0]    o_arch_regs [`RV_REG_NUM]
);

  logic [`RV_REG_AW-1:0] rs1;
  logic                  rs1_ren;
  logic [`RV_REG_AW-1:0] rs2;
  logic                  rs2_ren;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;
  logic                  ex_valid;
  logic                  ex_illegal;
  rv_uop_pkg::alu_op_t   ex_op;
  logic [`RV_XLEN-1:0]   ex_a;
  logic [`RV_XLEN-1:0]   ex_b;
  logic [`RV_REG_AW-1:0] ex_rd;
  logic                  ex_wen;
  logic [`RV_XLEN-1:0]   alu_result;

  rv_decode u_decode (
    .clk           (clk),
    .rst           (rst),
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .i_rs1_data    (rs1_data),
    .i_rs2_data    (rs2_data),
    .i_ex_wen      (ex_wen),
    .i_ex_rd       (ex_rd),
    .i_ex_result   (alu_result),
    .i_wb_wen      (o_commit_wen),
    .i_wb_rd       (o_commit_rd),
    .i_wb_data     (o_commit_data),
    .o_rs1         (rs1),
    .o_rs1_ren     (rs1_ren),
    .o_rs2         (rs2),
    .o_rs2_ren     (rs2_ren),
    .o_ex_valid    (ex_valid),
    .o_ex_illegal  (ex_illegal),
    .o_ex_op       (ex_op),
    .o_ex_a        (ex_a),
    .o_ex_b        (ex_b),
    .o_ex_rd       (ex_rd),
    .o_ex_wen      (ex_wen)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1),
    .i_rs1_ren  (rs1_ren),
    .i_rs2      (rs2),
    .i_rs2_ren  (rs2_ren),
    .i_rd       (o_commit_rd),
    .i_rd_wen   (o_commit_wen),
    .i_rd_data  (o_commit_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .o_regs     (o_arch_regs)
  );

  rv_alu u_alu (
    .i_op     (ex_op),
    .i_a      (ex_a),
    .i_b      (ex_b),
    .o_result (alu_result)
  );

  rv_commit u_commit (
    .clk          (clk),
    .rst          (rst),
    .i_ex_valid   (ex_valid),
    .i_ex_illegal (ex_illegal),
    .i_ex_rd      (ex_rd),
    .i_ex_wen     (ex_wen),
    .i_result     (alu_result),
    .o_wb_valid   (o_commit_valid),
    .o_wb_illegal (o_commit_illegal),
    .o_wb_rd      (o_commit_rd),
    .o_wb_wen     (o_commit_wen),
    .o_wb_data    (o_commit_data)
  );

endmodule

// File: verif/rv_exec_tb.sv
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module rv_exec_tb;

  localparam int RESET_CYCLES = 10;
  localparam int NUM_DIRECTED = 10;
  localparam int NUM_RANDOM   = 400;
  // gaps are at most 2, so one strobe every third cycle at worst
  localparam int MAX_CYCLES = RESET_CYCLES + 3 * (NUM_DIRECTED + NUM_RANDOM) + 50;

  typedef struct packed {
    logic                  illegal;
    logic                  wen;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   data;
  } commit_rec_t;

  logic                   clk;
  logic                   rst;
  logic                   i_instr_valid;
  logic [`RV_INSTR_W-1:0] i_instr;
  logic                   o_commit_valid;
  logic                   o_commit_illegal;
  logic [`RV_REG_AW-1:0]  o_commit_rd;
  logic                   o_commit_wen;
  logic [`RV_XLEN-1:0]    o_commit_data;
  logic [`RV_XLEN-1:0]    arch_regs [`RV_REG_NUM];

  logic [15:0]            lfsr;
  logic [`RV_XLEN-1:0]    issue_regs [`RV_REG_NUM];
  logic [`RV_XLEN-1:0]    arch_model [`RV_REG_NUM];
  commit_rec_t            pending [$];
  commit_rec_t            rec_in;
  commit_rec_t            exp_rec;
  logic                   exp_valid;
  logic                   strobe_d;
  int                     issue_count;
  int                     commit_count;
  int                     cycles;
  int                     errors;

  rv_exec_top u_dut (
    .clk              (clk),
    .rst              (rst),
    .i_instr_valid    (i_instr_valid),
    .i_instr          (i_instr),
    .o_commit_valid   (o_commit_valid),
    .o_commit_illegal (o_commit_illegal),
    .o_commit_rd      (o_commit_rd),
    .o_commit_wen     (o_commit_wen),
    .o_commit_data    (o_commit_data),
    .o_arch_regs      (arch_regs)
  );

  always #20 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic is_supported(input logic [6:0] opc);
    return opc == rv_isa_pkg::OPC_OP || opc == rv_isa_pkg::OPC_OP_IMM ||
           opc == rv_isa_pkg::OPC_LUI;
  endfunction

  // expected result straight from the rv64i definitions
  function automatic logic [`RV_XLEN-1:0] model_exec(
    input logic [`RV_INSTR_W-1:0] ins,
    input logic [`RV_XLEN-1:0]    a,
    input logic [`RV_XLEN-1:0]    b_reg
  );
    logic [`RV_XLEN-1:0] b;
    logic [5:0]          sh;
    logic                is_reg;
    is_reg = (ins[6:0] == rv_isa_pkg::OPC_OP);
    b      = is_reg ? b_reg : {{(`RV_XLEN-12){ins[31]}}, ins[31:20]};
    sh     = b[5:0];
    if (ins[6:0] == rv_isa_pkg::OPC_LUI) begin
      return {{(`RV_XLEN-32){ins[31]}}, ins[31:12], 12'h000};
    end
    case (ins[14:12])
      rv_isa_pkg::F3_ADD_SUB: return (is_reg && ins[30]) ? a - b : a + b;
      rv_isa_pkg::F3_SLL:     return a << sh;
      rv_isa_pkg::F3_SLT:     return {63'd0, $signed(a) < $signed(b)};
      rv_isa_pkg::F3_SLTU:    return {63'd0, a < b};
      rv_isa_pkg::F3_XOR:     return a ^ b;
      rv_isa_pkg::F3_SR: begin
        if (ins[30]) begin
          return $signed(a) >>> sh;
        end
        return a >> sh;
      end
      rv_isa_pkg::F3_OR:      return a | b;
      default:                return a & b;
    endcase
  endfunction

  // register fields only reach x0..x3 so dependencies stay dense
  task automatic gen_instr(output logic [`RV_INSTR_W-1:0] ins);
    logic [31:0] r;
    logic [31:0] w;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    rand_bits(13, r);
    rand_bits(32, w);
    f3  = r[5:3];
    alt = r[12] && (f3 == rv_isa_pkg::F3_ADD_SUB || f3 == rv_isa_pkg::F3_SR);
    imm = w[11:0];
    if (f3 == rv_isa_pkg::F3_SLL || f3 == rv_isa_pkg::F3_SR) begin
      imm[11:6] = {1'b0, alt, 4'b0};
    end
    if (r[2:0] < 3'd3) begin
      ins = {1'b0, alt, 5'b0, 3'b0, r[11:10], 3'b0, r[9:8], f3, 3'b0, r[7:6],
             rv_isa_pkg::OPC_OP};
    end else if (r[2:0] < 3'd6) begin
      ins = {imm, 3'b0, r[9:8], f3, 3'b0, r[7:6], rv_isa_pkg::OPC_OP_IMM};
    end else if (r[2:0] == 3'd6) begin
      ins = {w[31:12], 3'b0, r[7:6], rv_isa_pkg::OPC_LUI};
    end else begin
      ins = w;
      // supported opcodes all have bit 6 clear
      if (is_supported(w[6:0])) begin
        ins[6] = 1'b1;
      end
    end
  endtask

  task automatic send(input logic [`RV_INSTR_W-1:0] ins, input int gap);
    i_instr_valid <= 1'b1;
    i_instr       <= ins;
    @(posedge clk);
    i_instr_valid <= 1'b0;
    repeat (gap) @(posedge clk);
  endtask

  // reference model, issue order for results and commit timing for the state view
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_REG_NUM; i++) begin
        issue_regs[i] = '0;
        arch_model[i] <= '0;
      end
      pending.delete();
      exp_valid <= 1'b0;
      strobe_d  <= 1'b0;
    end else begin
      exp_valid <= strobe_d;
      if (strobe_d) begin
        exp_rec <= pending[0];
        if (pending[0].wen && pending[0].rd != '0) begin
          arch_model[pending[0].rd] <= pending[0].data;
        end
        void'(pending.pop_front());
      end
      if (i_instr_valid) begin
        rec_in.illegal = !is_supported(i_instr[6:0]);
        rec_in.wen     = !rec_in.illegal;
        rec_in.rd      = i_instr[11:7];
        rec_in.data    = model_exec(i_instr, issue_regs[i_instr[19:15]],
                                    issue_regs[i_instr[24:20]]);
        if (rec_in.wen && rec_in.rd != '0) begin
          issue_regs[rec_in.rd] = rec_in.data;
        end
        pending.push_back(rec_in);
        issue_count++;
      end
      if (o_commit_valid) begin
        commit_count++;
      end
      strobe_d <= i_instr_valid;
    end
  end

  a_rst_quiet: assert property (@(posedge clk)
    $fell(rst) |-> (!o_commit_valid && !o_commit_wen && !o_commit_illegal))
    else begin
      errors++;
      $display("commit record not idle right after reset");
    end

  a_latency: assert property (@(posedge clk) disable iff (rst)
    i_instr_valid |-> ##2 o_commit_valid)
    else begin
      errors++;
      $display("no commit two cycles after a strobe");
    end

  a_valid: assert property (@(posedge clk) disable iff (rst) o_commit_valid == exp_valid)
    else begin
      errors++;
      $display("Fail o_commit_valid got %h exp %h", $sampled(o_commit_valid),
               $sampled(exp_valid));
    end

  a_record: assert property (@(posedge clk) disable iff (rst)
    o_commit_valid |-> {o_commit_illegal, o_commit_wen, o_commit_rd} ==
                       {exp_rec.illegal, exp_rec.wen, exp_rec.rd})
    else begin
      errors++;
      $display("Fail {o_commit_illegal,o_commit_wen,o_commit_rd} got %h exp %h",
               $sampled({o_commit_illegal, o_commit_wen, o_commit_rd}),
               $sampled({exp_rec.illegal, exp_rec.wen, exp_rec.rd}));
    end

  a_data: assert property (@(posedge clk) disable iff (rst)
    (o_commit_valid && exp_rec.wen) |-> o_commit_data == exp_rec.data)
    else begin
      errors++;
      $display("Fail o_commit_data got %h exp %h", $sampled(o_commit_data),
               $sampled(exp_rec.data));
    end

  // entry 0 doubles as the x0 check
  for (genvar g = 0; g < `RV_REG_NUM; g++) begin : g_reg_chk
    a_reg: assert property (@(posedge clk) disable iff (rst) arch_regs[g] == arch_model[g])
      else begin
        errors++;
        $display("Fail o_arch_regs[%0d] got %h exp %h", g, $sampled(arch_regs[g]),
                 $sampled(arch_model[g]));
      end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("run did not finish within %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    logic [31:0]            r;
    logic [`RV_INSTR_W-1:0] ins;
    clk           = 1'b0;
    rst           = 1'b1;
    i_instr_valid = 1'b0;
    i_instr       = '0;
    lfsr          = 16'd27905;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    // lui, addi, add, sub chain with gaps 0, 0, 1, 2
    send(32'h800000B7, 0);
    send(32'hFFF08113, 0);
    send(32'h002081B3, 1);
    send(32'h401181B3, 2);
    // addi x0 then add reading x0
    send(32'h00508013, 0);
    send(32'h002000B3, 0);
    send(32'h43F0D113, 1);
    send(32'h0020A1B3, 0);
    // lw is outside the supported set
    send(32'h00412183, 0);
    send(32'h00318133, 2);
    for (int n = 0; n < NUM_RANDOM; n++) begin
      gen_instr(ins);
      rand_bits(2, r);
      send(ins, int'(r[1:0]) % 3);
    end
    do begin
      @(negedge clk);
    end while (commit_count < issue_count);
    if (commit_count != issue_count) begin
      $display("more commits than strobed instructions");
    end
    $display("%0d instructions, %0d commits, %0d errors", issue_count, commit_count, errors);
    if (errors == 0 && commit_count == issue_count) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: rv_exec.f
+incdir+include
verilog/rv_isa_pkg.sv
verilog/rv_uop_pkg.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/rv_commit.sv
verilog/rv_exec_top.sv
verif/rv_exec_tb.sv

// File: Makefile
TOP := rv_exec_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f rv_exec.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
